// ==== vlog.f ====
+incdir+include
src/gpu_pkg.sv
src/smem_if.sv
src/gpu_alu.sv
src/gpu_core.sv
src/smem_arbiter.sv
src/gpu_cluster.sv
tb/gpu_cluster_props.sv
tb/gpu_cluster_tb.sv

// ==== Makefile ====
# Verilator build and run of the GPU cluster testbench

TOP := gpu_cluster_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== tb/gpu_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gpu_defs.svh"

module gpu_cluster_tb
	import gpu_pkg::*;
();

	// 20 programs of 16 instructions at worst-case memory wait
	localparam int WATCHDOG_CYCLES = 20 * `GPU_PROG_LEN * (5 + 4 * `GPU_NUM_CORES);

	logic       clk;
	logic       reset;
	logic       val_ins;
	instr_t     instruction;
	logic       rtr;
	logic       ready;
	logic       host_rd_en;
	smem_addr_t host_addr;
	data_t      host_rd_data;
	data_t      exp_byte;                     // compared in props
	int         fail_cnt;

	instr_t      prog [`GPU_PROG_LEN];       // program being loaded
	data_t       exp_mem [`GPU_SMEM_DEPTH];  // model of the scratch memory
	bit          written [`GPU_SMEM_DEPTH];  // bytes stored by this program
	logic [31:0] seed = 32'ha7e794f7;
	int          n_tests;
	int          fail_base;
	data_t       x;
	data_t       y;

	gpu_cluster i_gpu_cluster (
		.clk          (clk),
		.reset        (reset),
		.val_ins      (val_ins),
		.instruction  (instruction),
		.rtr          (rtr),
		.ready        (ready),
		.host_rd_en   (host_rd_en),
		.host_addr    (host_addr),
		.host_rd_data (host_rd_data)
	);

	gpu_cluster_props i_gpu_cluster_props (
		.clk          (clk),
		.reset        (reset),
		.val_ins      (val_ins),
		.rtr          (rtr),
		.ready        (ready),
		.host_rd_en   (host_rd_en),
		.host_rd_data (host_rd_data),
		.exp_byte     (exp_byte),
		.fail_cnt     (fail_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, the cluster never went back to ready");
		$display("test failed");
		$finish;
	end

	function automatic data_t next_rand();
		seed ^= seed << 13;               // xorshift32
		seed ^= seed >> 17;
		seed ^= seed << 5;
		return seed[7:0];
	endfunction

	function automatic instr_t enc(input int op, input int a, input int b, input int d);
		return {op[3:0], a[3:0], b[3:0], d[3:0]};
	endfunction

	// immediate move needs dst r8..r15
	function automatic instr_t movi(input data_t imm, input int d);
		return {4'd12, imm, d[3:0]};
	endfunction

	function automatic void fill_prog(input instr_t w);
		foreach (prog[i])
			prog[i] = w;
	endfunction

	////////////////////////////////////////////////////////////////////
	// ISA model run per core
	////////////////////////////////////////////////////////////////////

	function automatic void run_model(input core_id_t id);
		data_t    r [`GPU_NUM_REGS];
		reg_idx_t pc;
		instr_t   w;
		data_t    a;
		data_t    b;
		data_t    v;
		bit       done;
		pc = '0;
		done = 1'b0;
		while (!done)
		begin
			w = prog[pc];
			a = r[w[11:8]];
			b = r[w[7:4]];
			v = '0;
			case (w[15:12])
				4'd1:  v = a + b;
				4'd2:  v = a - b;
				4'd3:  v = a * b;
				4'd4:  v = (b == '0) ? 8'hff : a / b;
				4'd5:  v = (a >= b) ? 8'd1 : 8'd0;
				4'd6:  v = a >> b[3:0];
				4'd7:  v = a << b[3:0];
				4'd8:  v = a & b;
				4'd9:  v = a | b;
				4'd10: v = a ^ b;
				4'd11: v = exp_mem[b];          // only b selects one of 256 bytes
				4'd12: v = w[3] ? w[11:4] : data_t'(id);
				4'd13:
				begin
					exp_mem[b] = r[w[3:0]];
					written[b] = 1'b1;
				end
				default: ;
			endcase
			if ((w[15:12] >= 4'd1) && (w[15:12] <= 4'd12))
				r[w[3:0]] = v;
			if (w[15:12] == 4'd15)
				done = 1'b1;                   // halt
			else if ((w[15:12] == 4'd14) && (a != '0))
				pc = w[7:4];                   // taken branch
			else if ((pc == 4'd15) && (w[15:12] != 4'd14))
				done = 1'b1;                   // off the end
			else
				pc = pc + 4'd1;
		end
	endfunction

	////////////////////////////////////////////////////////////////////
	// programs
	////////////////////////////////////////////////////////////////////

	// results of two ops on x+id and y land at id*16+op
	function automatic void build_arith(input int op1, input int op2, input data_t xv,
		input data_t yv);
		fill_prog('0);
		prog[0] = movi(xv, 8);
		prog[1] = movi(yv, 9);
		prog[2] = enc(12, 0, 0, 0);
		prog[3] = movi(8'd4, 11);
		prog[4] = enc(7, 0, 11, 1);
		prog[5] = enc(1, 8, 0, 2);
		prog[6] = enc(op1, 2, 9, 3);
		prog[7] = movi(data_t'(op1), 10);
		prog[8] = enc(1, 1, 10, 4);
		prog[9] = enc(13, 0, 4, 3);
		prog[10] = enc(op2, 2, 9, 3);
		prog[11] = movi(data_t'(op2), 10);
		prog[12] = enc(1, 1, 10, 4);
		prog[13] = enc(13, 0, 4, 3);
		prog[14] = enc(15, 0, 0, 0);
	endfunction

	// store x at 0x80+id*16 then reload it and store the copy one byte up
	function automatic void build_load_store(input data_t xv);
		fill_prog(enc(15, 0, 0, 0));
		prog[0] = movi(xv, 8);
		prog[1] = enc(12, 0, 0, 0);
		prog[2] = movi(8'd4, 11);
		prog[3] = enc(7, 0, 11, 1);
		prog[4] = movi(8'h80, 12);
		prog[5] = enc(1, 1, 12, 2);
		prog[6] = enc(13, 0, 2, 8);
		prog[7] = enc(11, 0, 2, 3);
		prog[8] = movi(8'd1, 13);
		prog[9] = enc(1, 2, 13, 4);
		prog[10] = enc(13, 0, 4, 3);
	endfunction

	// count r8 = n+id down to zero and store the loop count at 0xc0+id*16
	function automatic void build_countdown(input data_t n);
		fill_prog(enc(15, 0, 0, 0));
		prog[0] = movi(n, 13);
		prog[1] = movi(8'd1, 9);
		prog[2] = enc(12, 0, 0, 0);
		prog[3] = enc(1, 13, 0, 8);
		prog[4] = movi(8'd4, 11);
		prog[5] = enc(7, 0, 11, 1);
		prog[6] = movi(8'hc0, 12);
		prog[7] = enc(1, 1, 12, 2);
		prog[8] = movi(8'd0, 10);
		prog[9] = enc(1, 10, 9, 10);          // loop top
		prog[10] = enc(2, 8, 9, 8);
		prog[11] = enc(14, 8, 9, 0);          // back to 9 while r8 != 0
		prog[12] = enc(13, 0, 2, 10);
	endfunction

	// all cores store three bytes in lockstep at 0x40+id*16
	function automatic void build_contention(input data_t xv);
		fill_prog('0);
		prog[0] = enc(12, 0, 0, 0);
		prog[1] = movi(8'd4, 11);
		prog[2] = enc(7, 0, 11, 1);
		prog[3] = movi(xv, 8);
		prog[4] = enc(1, 8, 0, 2);
		prog[5] = movi(8'h40, 12);
		prog[6] = enc(1, 1, 12, 4);
		prog[7] = movi(8'd1, 9);
		for (int j = 0; j < 3; j++)
		begin
			prog[8 + 3 * j] = enc(13, 0, 4, 2);
			if (j < 2)
			begin
				prog[9 + 3 * j] = enc(1, 4, 9, 4);     // next address
				prog[10 + 3 * j] = enc(1, 2, 9, 2);    // next byte
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////
	// bus tasks
	////////////////////////////////////////////////////////////////////

	task automatic check_byte(input logic [7:0] addr, input data_t exp);
		@(posedge clk);
		host_rd_en <= 1'b1;
		host_addr <= smem_addr_t'(addr);
		exp_byte <= exp;
		@(posedge clk);
		host_rd_en <= 1'b0;
		repeat (2) @(posedge clk);            // compare lands in this gap
	endtask

	task automatic run_program();
		foreach (written[k])
			written[k] = 1'b0;
		for (int i = 0; i < `GPU_PROG_LEN; i++)
		begin
			@(posedge clk);
			val_ins <= 1'b1;
			instruction <= prog[i];
		end
		@(posedge clk);
		val_ins <= 1'b0;
		do
			@(negedge clk);
		while (!ready);
		for (int c = 0; c < `GPU_NUM_CORES; c++)
			run_model(core_id_t'(c));
		for (int k = 0; k < `GPU_SMEM_DEPTH; k++)
			if (written[k])
				check_byte(8'(k), exp_mem[k]);
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %0d %s: %0d errors", n_tests, name, fail_cnt - fail_base);
		fail_base = fail_cnt;
	endtask

	initial
	begin
		reset = 1'b1;
		val_ins = 1'b0;
		instruction = '0;
		host_rd_en = 1'b0;
		host_addr = '0;
		exp_byte = '0;
		n_tests = 0;
		fail_base = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		fill_prog(enc(15, 0, 0, 0));          // halts only
		run_program();
		end_test("handshake");

		for (int g = 0; g < 5; g++)
		begin
			x = next_rand();
			y = next_rand();
			build_arith(2 * g + 1, 2 * g + 2, x, y);
			run_program();
		end
		end_test("arithmetic");

		x = next_rand();
		build_load_store(x);
		run_program();
		end_test("load after store");

		build_countdown((next_rand() & 8'h07) + 8'd1);
		run_program();
		end_test("branch loop");

		build_contention(next_rand());
		run_program();
		end_test("contention");

		build_load_store(x ^ 8'h5a);          // new bytes over test 3
		run_program();
		end_test("reload");

		$display("%0d tests, %0d errors", n_tests, fail_cnt);
		if (fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/gpu_cluster_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gpu_defs.svh"

module gpu_cluster_props
	import gpu_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  val_ins,
	input  logic  rtr,
	input  logic  ready,
	input  logic  host_rd_en,
	input  data_t host_rd_data,
	input  data_t exp_byte,       // held by the testbench until the check
	output int    fail_cnt
);

	localparam reg_idx_t LAST_WORD = reg_idx_t'(`GPU_PROG_LEN - 1);

	reg_idx_t word_cnt;           // program words taken so far

	initial fail_cnt = 0;

	task automatic note_fail(input string msg);
		fail_cnt++;
		$display("%s", msg);
	endtask

	always_ff @(posedge clk)
	begin
		if (reset)
			word_cnt <= '0;
		else if (val_ins && rtr)
			word_cnt <= word_cnt + 1'b1;   // wraps after the last word
	end

	////////////////////////////////////////////////////////////////////
	// program bus handshake
	////////////////////////////////////////////////////////////////////

	a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> (rtr && ready))
		else note_fail($sformatf("Fail %0t rtr&ready got 0 expected 1", $time));

	a_ready_falls: assert property (@(posedge clk) disable iff (reset)
		(val_ins && rtr && ready) |=> !ready)
		else note_fail($sformatf("Fail %0t ready got 1 expected 0", $time));

	a_rtr_holds: assert property (@(posedge clk) disable iff (reset)
		(val_ins && rtr && (word_cnt != LAST_WORD)) |=> rtr)
		else note_fail($sformatf("Fail %0t rtr got 0 expected 1", $time));

	a_rtr_falls: assert property (@(posedge clk) disable iff (reset)
		(val_ins && rtr && (word_cnt == LAST_WORD)) |=> !rtr)
		else note_fail($sformatf("Fail %0t rtr got 1 expected 0", $time));

	// no core idle while the cluster still runs
	a_busy_while_running: assert property (@(posedge clk) disable iff (reset)
		!rtr |-> !ready)
		else note_fail($sformatf("Fail %0t ready got 1 expected 0", $time));

	a_done_together: assert property (@(posedge clk) disable iff (reset)
		$rose(rtr) |-> ready)
		else note_fail($sformatf("Fail %0t ready got 0 expected 1", $time));

	////////////////////////////////////////////////////////////////////
	// host readback against the model
	////////////////////////////////////////////////////////////////////

	a_readback: assert property (@(posedge clk) disable iff (reset)
		host_rd_en |=> (host_rd_data == exp_byte))
		else note_fail($sformatf("Fail %0t host_rd_data got %h expected %h",
			$time, host_rd_data, exp_byte));

endmodule

`default_nettype wire

// ==== src/gpu_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gpu_defs.svh"

module gpu_cluster
	import gpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       val_ins,       // broadcast program bus
	input  instr_t     instruction,
	output logic       rtr,           // all cores can take words
	output logic       ready,         // all cores idle
	input  logic       host_rd_en,
	input  smem_addr_t host_addr,
	output data_t      host_rd_data
);

	logic [`GPU_NUM_CORES-1:0] rtr_core;
	logic [`GPU_NUM_CORES-1:0] ready_core;

	smem_if mem_if [`GPU_NUM_CORES] ();   // one port per core

	////////////////////////////////////////////////////////////////////
	// cores
	////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `GPU_NUM_CORES; g++)
	begin : g_core
		gpu_core i_gpu_core (
			.clk         (clk),
			.reset       (reset),
			.core_id     (core_id_t'(g)),
			.val_ins     (val_ins),
			.instruction (instruction),
			.rtr         (rtr_core[g]),
			.ready       (ready_core[g]),
			.mem         (mem_if[g].core)
		);
	end

	smem_arbiter i_smem_arbiter (
		.clk          (clk),
		.reset        (reset),
		.ports        (mem_if),
		.host_rd_en   (host_rd_en),
		.host_addr    (host_addr),
		.host_rd_data (host_rd_data)
	);

	assign rtr = &rtr_core;
	assign ready = &ready_core;

endmodule

`default_nettype wire

// ==== src/smem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gpu_defs.svh"

module smem_arbiter
	import gpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	smem_if.arbiter    ports [`GPU_NUM_CORES],
	input  logic       host_rd_en,
	input  smem_addr_t host_addr,
	output data_t      host_rd_data   // one cycle after host_rd_en
);

	localparam int N = `GPU_NUM_CORES;
	localparam int IW = $clog2(N);
	localparam int AW = $clog2(`GPU_SMEM_DEPTH);

	typedef logic [IW-1:0] cidx_t;

	data_t      mem [`GPU_SMEM_DEPTH];   // shared scratch bytes
	logic [N-1:0] req;
	logic [N-1:0] st;
	smem_addr_t addr_a  [N];
	data_t      wdata_a [N];
	logic [N-1:0] val_q;                 // one-hot, the grant in flight
	data_t      rdata_q;
	cidx_t      last_q;                  // last core served
	cidx_t      pick;
	logic       pick_vld;
	logic       do_grant;

	// flatten the interface array
	for (genvar i = 0; i < N; i++)
	begin : g_port
		assign req[i] = ports[i].req_ld | ports[i].req_st;
		assign st[i] = ports[i].req_st;
		assign addr_a[i] = ports[i].addr;
		assign wdata_a[i] = ports[i].wdata;
		assign ports[i].val_data = val_q[i];
		assign ports[i].rdata = rdata_q;
	end

	////////////////////////////////////////////////////////////////////
	// round-robin pick, starting after last_q
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		int cand;
		pick = '0;
		pick_vld = 1'b0;
		// walk down so the nearest requester wins
		for (int k = N; k >= 1; k--)
		begin
			cand = (int'(last_q) + k) % N;
			if (req[cand])
			begin
				pick = cidx_t'(cand);
				pick_vld = 1'b1;
			end
		end
	end

	assign do_grant = (val_q == '0) && pick_vld;   // one grant at a time

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			val_q <= '0;
			last_q <= '0;
		end
		else
		begin
			val_q <= '0;                  // val_data is a pulse
			if (do_grant)
			begin
				val_q <= N'(1) << pick;
				last_q <= pick;
			end
		end
	end

	// access happens on the grant edge, answer shows with val_data
	always_ff @(posedge clk)
	begin
		if (do_grant)
		begin
			if (st[pick])
				mem[addr_a[pick][AW-1:0]] <= wdata_a[pick];
			rdata_q <= mem[addr_a[pick][AW-1:0]];
		end
		if (host_rd_en)
			host_rd_data <= mem[host_addr[AW-1:0]];
	end

	a_val_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(val_q));

	// a core must still be requesting when its answer arrives
	a_val_to_req: assert property (@(posedge clk) disable iff (reset)
		(val_q != '0) |-> ((val_q & req) == val_q));

endmodule

`default_nettype wire

// ==== src/gpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gpu_defs.svh"

module gpu_core
	import gpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  core_id_t core_id,
	input  logic     val_ins,      // program word strobe
	input  instr_t   instruction,
	output logic     rtr,          // ready to receive program
	output logic     ready,        // idle, results readable
	smem_if.core     mem
);

	localparam reg_idx_t LAST_PC = reg_idx_t'(`GPU_PROG_LEN - 1);

	core_state_e state;

	instr_t   prog [`GPU_PROG_LEN];   // program store
	data_t    rf   [`GPU_NUM_REGS];   // register file
	reg_idx_t load_cnt;              // next program slot
	reg_idx_t pc;                    // next sequential fetch
	reg_idx_t cur_pc;                // pc of instruction in flight
	logic     br_tkn;
	reg_idx_t br_target;

	instr_t     ir_d, ir_e, ir_m, ir_wb;
	data_t      a_e, b_e;
	data_t      st_e, st_m;          // store byte follows the instr
	smem_addr_t o_m;
	data_t      o_wb;                // alu result or load byte
	smem_addr_t alu_result;

	opcode_e  op_e, op_m, op_wb;
	reg_idx_t fetch_pc;
	logic     prog_end;
	logic     rf_we;

	assign op_e = opcode_e'(ir_e[15:12]);
	assign op_m = opcode_e'(ir_m[15:12]);
	assign op_wb = opcode_e'(ir_wb[15:12]);

	assign fetch_pc = br_tkn ? br_target : pc;   // taken branch redirects
	// halt, or pc 15 falls off the end unless it branches
	assign prog_end = (op_wb == OP_HALT) || ((cur_pc == LAST_PC) && (op_wb != OP_BRNZ));
	assign rf_we = (op_wb >= OP_ADD) && (op_wb <= OP_MOV);   // ops 1..12 write dst

	gpu_alu i_gpu_alu (
		.op      (op_e),
		.a       (a_e),
		.b       (b_e),
		.ir      (ir_e),
		.core_id (core_id),
		.result  (alu_result)
	);

	////////////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_LOAD;
			rtr <= 1'b1;
			ready <= 1'b1;
			load_cnt <= '0;
			pc <= '0;
			br_tkn <= 1'b0;
			mem.req_ld <= 1'b0;
			mem.req_st <= 1'b0;
		end
		else
		begin
			case (state)
				ST_LOAD:
				begin
					if (val_ins)
					begin
						ready <= 1'b0;        // busy from first word on
						if (load_cnt == LAST_PC)
						begin
							load_cnt <= '0;
							rtr <= 1'b0;
							state <= ST_FETCH;
						end
						else
							load_cnt <= load_cnt + 1'b1;
					end
				end
				ST_FETCH:
				begin
					pc <= fetch_pc + 1'b1;
					br_tkn <= 1'b0;           // redirect consumed
					state <= ST_DECODE;
				end
				ST_DECODE: state <= ST_EXEC;
				ST_EXEC:
				begin
					if ((op_e == OP_BRNZ) && (a_e != '0))
						br_tkn <= 1'b1;
					state <= ST_MEM;
				end
				ST_MEM:
				begin
					if (op_m == OP_LD)
					begin
						mem.req_ld <= 1'b1;
						state <= ST_MEM_WAIT;
					end
					else if (op_m == OP_ST)
					begin
						mem.req_st <= 1'b1;
						state <= ST_MEM_WAIT;
					end
					else
						state <= ST_WB;
				end
				ST_MEM_WAIT:
				begin
					if (mem.val_data)          // stall until granted
					begin
						mem.req_ld <= 1'b0;
						mem.req_st <= 1'b0;
						state <= ST_WB;
					end
				end
				ST_WB:
				begin
					if (prog_end)
					begin
						state <= ST_LOAD;
						rtr <= 1'b1;
						ready <= 1'b1;
						pc <= '0;
						br_tkn <= 1'b0;
					end
					else
						state <= ST_FETCH;
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// datapath registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if ((state == ST_LOAD) && val_ins)
			prog[load_cnt] <= instruction;
		if ((state == ST_WB) && rf_we)
			rf[ir_wb[3:0]] <= o_wb;
	end

	always_ff @(posedge clk)
	begin
		case (state)
			ST_FETCH:
			begin
				ir_d <= prog[fetch_pc];
				cur_pc <= fetch_pc;
			end
			ST_DECODE:
			begin
				ir_e <= ir_d;
				a_e <= rf[ir_d[11:8]];
				b_e <= rf[ir_d[7:4]];
				st_e <= rf[ir_d[3:0]];     // dst field is store source
			end
			ST_EXEC:
			begin
				ir_m <= ir_e;
				o_m <= alu_result;
				st_m <= st_e;
				br_target <= ir_e[7:4];
			end
			ST_MEM:
			begin
				ir_wb <= ir_m;
				o_wb <= o_m[7:0];
				mem.addr <= o_m;
				mem.wdata <= st_m;
			end
			ST_MEM_WAIT:
			begin
				if (mem.val_data)
					o_wb <= mem.rdata;      // load data, ignored for stores
			end
			default: ;
		endcase
	end

	// request lives only while waiting on the arbiter
	a_req_in_wait: assert property (@(posedge clk) disable iff (reset)
		(mem.req_ld || mem.req_st) |-> (state == ST_MEM_WAIT));

	a_req_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem.req_ld && mem.req_st));

endmodule

`default_nettype wire

// ==== src/gpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_alu
	import gpu_pkg::*;
(
	input  opcode_e    op,
	input  data_t      a,
	input  data_t      b,
	input  instr_t     ir,       // for the immediate field
	input  core_id_t   core_id,
	output smem_addr_t result    // byte result or 12-bit address
);

	// results of ops 1..10 are 8 bits, zero extended
	always_comb
	begin
		result = '0;
		case (op)
			OP_ADD:   result = smem_addr_t'(a + b);
			OP_SUB:   result = smem_addr_t'(a - b);
			OP_MUL:   result = smem_addr_t'(a * b);   // low byte kept
			OP_DIV:
			begin
				if (b == '0)
					result = smem_addr_t'(8'hff);      // div by zero, all ones
				else
					result = smem_addr_t'(a / b);
			end
			OP_CMPGE: result = smem_addr_t'(a >= b);
			OP_SHR:   result = smem_addr_t'(a >> b[3:0]);
			OP_SHL:   result = smem_addr_t'(a << b[3:0]);
			OP_AND:   result = smem_addr_t'(a & b);
			OP_OR:    result = smem_addr_t'(a | b);
			OP_XOR:   result = smem_addr_t'(a ^ b);
			OP_LD,
			OP_ST:    result = {a[3:0], b};           // page from a, offset from b
			OP_MOV:
			begin
				if (ir[3])
					result = smem_addr_t'(ir[11:4]);   // 8-bit immediate
				else
					result = smem_addr_t'(core_id);
			end
			default:  result = '0;                    // nop, branch, halt
		endcase
	end

endmodule

`default_nettype wire

// ==== src/smem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one core's port into the shared scratch memory
interface smem_if
	import gpu_pkg::*;
();

	logic       req_ld;    // held until val_data
	logic       req_st;
	smem_addr_t addr;
	data_t      wdata;     // store byte
	data_t      rdata;     // load byte, valid with val_data
	logic       val_data;  // one cycle per grant

	modport core (
		output req_ld, req_st, addr, wdata,
		input  rdata, val_data
	);

	modport arbiter (
		input  req_ld, req_st, addr, wdata,
		output rdata, val_data
	);

endinterface

`default_nettype wire

// ==== src/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

	typedef logic [15:0] instr_t;      // op | src a | src b | dst
	typedef logic [7:0]  data_t;       // register / memory byte
	typedef logic [11:0] smem_addr_t;  // only low byte decoded
	typedef logic [3:0]  reg_idx_t;    // register index or pc
	typedef logic [3:0]  core_id_t;

	////////////////////////////////////////////////////////////////////
	// instruction set
	////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_MUL   = 4'd3,
		OP_DIV   = 4'd4,
		OP_CMPGE = 4'd5,   // a >= b gives 1
		OP_SHR   = 4'd6,
		OP_SHL   = 4'd7,
		OP_AND   = 4'd8,
		OP_OR    = 4'd9,
		OP_XOR   = 4'd10,
		OP_LD    = 4'd11,  // addr {a[3:0], b}
		OP_MOV   = 4'd12,  // imm or core id
		OP_ST    = 4'd13,  // stores dst field reg
		OP_BRNZ  = 4'd14,  // target in bits 7..4
		OP_HALT  = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ST_LOAD, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_MEM_WAIT, ST_WB
	} core_state_e;

endpackage

`default_nettype wire

// ==== include/gpu_defs.svh ====
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

////////////////////////////////////////////////////////////////////////
// cluster sizing
////////////////////////////////////////////////////////////////////////

// cores sharing the scratch memory
`define GPU_NUM_CORES 4

// words in one program, pc wraps at this count
`define GPU_PROG_LEN 16

// general registers per core
`define GPU_NUM_REGS 16

// shared scratch memory, one byte per entry
`define GPU_SMEM_DEPTH 256

`endif
